// File: udp_axi_pkg.sv
package udp_axi_pkg;

    localparam logic [7:0] OP_WRITE       = 8'd1;
    localparam logic [7:0] OP_READ        = 8'd2;

    localparam logic [7:0] STATUS_OK      = 8'd0;
    localparam logic [7:0] STATUS_AXI_ERR = 8'd1;
    localparam logic [7:0] STATUS_BAD_OP  = 8'd2;
    localparam logic [7:0] STATUS_BAD_LEN = 8'd3;

    localparam logic [1:0] BURST_INCR     = 2'b01;
    localparam logic [1:0] RESP_OKAY      = 2'b00;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  tag;
        logic [7:0]  len;     // beats minus one
        logic [31:0] addr;
        logic [7:0]  status;  // early status from the parser
    } cmd_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } wbeat_t;

    typedef struct packed {
        logic [31:0] data;
        logic        err;
    } rbeat_t;

    typedef struct packed {
        logic [1:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [1:0]  burst;
    } axi_aw_t;

    typedef struct packed {
        logic [1:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] id;
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [1:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] tag;
        logic [7:0] status;
        logic [7:0] len;
    } reply_t;

endpackage

// File: word_fifo.sv
`timescale 1ns/1ps
module word_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  logic     gmii_rx_clk,
    input  logic     rst_n,
    input  logic     clear,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    assign pop_data = mem[rd_ptr];  // show-ahead head
    assign empty    = (count == '0);
    assign full     = (count == (AW+1)'(DEPTH));

    always_ff @(posedge gmii_rx_clk) begin
        if (!rst_n || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // producer and consumer sit in other modules
    assert property (@(posedge gmii_rx_clk) disable iff (!rst_n || clear)
        !(push && full) && !(pop && empty))
        else $error("word_fifo push on full or pop on empty");

endmodule

// File: udp_cmd_parser.sv
`timescale 1ns/1ps
module udp_cmd_parser #(
    parameter int MAX_BEATS = 16
) (
    input  logic                gmii_rx_clk,
    input  logic                rst_n,
    input  logic                rec_en,
    input  logic [31:0]         rec_data,
    input  logic                rec_pkt_done,
    input  logic                reply_done,
    output logic                cmd_valid,
    output udp_axi_pkg::cmd_t   cmd,
    output logic                wfifo_push,
    output udp_axi_pkg::wbeat_t wfifo_beat,
    output logic                wfifo_clear
);
    udp_axi_pkg::cmd_t cur;
    logic              busy;
    logic              skip;      // packet arrived while busy
    logic              take;
    logic              is_write;
    logic              len_ok;
    logic [15:0]       wcnt;
    logic [15:0]       beat_num;
    logic [15:0]       exp_cnt;
    logic [7:0]        status;

    assign take     = rec_en && !busy && !skip;
    assign is_write = (cur.opcode == udp_axi_pkg::OP_WRITE);
    assign beat_num = wcnt - 16'd2;
    assign len_ok   = ({8'd0, cur.len} < 16'(MAX_BEATS));
    assign exp_cnt  = is_write ? {8'd0, cur.len} + 16'd3 : 16'd2;

    assign wfifo_push = take && is_write && len_ok && (wcnt >= 16'd2) &&
                        (beat_num <= {8'd0, cur.len});
    assign wfifo_beat = udp_axi_pkg::wbeat_t'{
        data: rec_data,
        strb: 4'hf,
        last: (beat_num == {8'd0, cur.len})
    };

    always_comb begin
        if (wcnt < 16'd2) begin
            status = udp_axi_pkg::STATUS_BAD_LEN;  // header or address missing
        end else if (!is_write && cur.opcode != udp_axi_pkg::OP_READ) begin
            status = udp_axi_pkg::STATUS_BAD_OP;
        end else if (!len_ok || wcnt != exp_cnt) begin
            status = udp_axi_pkg::STATUS_BAD_LEN;
        end else begin
            status = udp_axi_pkg::STATUS_OK;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            skip        <= 1'b0;
            wcnt        <= 16'd0;
            cmd_valid   <= 1'b0;
            wfifo_clear <= 1'b0;
        end else begin
            cmd_valid   <= 1'b0;
            wfifo_clear <= 1'b0;
            if (take) begin
                wcnt <= wcnt + 16'd1;
            end
            if (rec_en && busy) begin
                skip <= 1'b1;
            end
            if (rec_pkt_done) begin
                wcnt <= 16'd0;
                skip <= 1'b0;
                if (!busy && !skip) begin
                    busy        <= 1'b1;
                    cmd_valid   <= 1'b1;
                    wfifo_clear <= (status != udp_axi_pkg::STATUS_OK);  // drop partial beats
                end
            end
            if (reply_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (take && wcnt == 16'd0) begin
            cur.opcode <= rec_data[31:24];
            cur.tag    <= rec_data[23:16];
            cur.len    <= rec_data[7:0];
        end
        if (take && wcnt == 16'd1) begin
            cur.addr <= rec_data;
        end
        if (rec_pkt_done) begin
            cmd <= udp_axi_pkg::cmd_t'{
                opcode: cur.opcode,
                tag:    cur.tag,
                len:    cur.len,
                addr:   cur.addr,
                status: status
            };
        end
    end

endmodule

// File: axi_burst_master.sv
`timescale 1ns/1ps
module axi_burst_master #(
    parameter logic [1:0] AXI_ID = 2'd0
) (
    input  logic                 gmii_rx_clk,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    input  udp_axi_pkg::cmd_t    cmd,
    output logic                 wfifo_pop,
    input  udp_axi_pkg::wbeat_t  wfifo_beat,
    output logic                 rfifo_push,
    output udp_axi_pkg::rbeat_t  rfifo_beat,
    output logic                 axi_done,
    output logic                 axi_err,
    output udp_axi_pkg::axi_aw_t aw,
    output logic                 aw_valid,
    input  logic                 aw_ready,
    output udp_axi_pkg::axi_w_t  w,
    output logic                 w_valid,
    input  logic                 w_ready,
    input  udp_axi_pkg::axi_b_t  b,
    input  logic                 b_valid,
    output logic                 b_ready,
    output udp_axi_pkg::axi_ar_t ar,
    output logic                 ar_valid,
    input  logic                 ar_ready,
    input  udp_axi_pkg::axi_r_t  r,
    input  logic                 r_valid,
    output logic                 r_ready
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_AW,
        S_W,
        S_B,
        S_AR,
        S_R
    } state_t;

    state_t state;
    logic   err_acc;  // sticky over read beats
    logic   b_bad;
    logic   r_bad;

    assign b_bad = (b.resp != udp_axi_pkg::RESP_OKAY) || (b.id != AXI_ID);
    assign r_bad = (r.resp != udp_axi_pkg::RESP_OKAY) || (r.id != AXI_ID);

    assign aw_valid = (state == S_AW);
    assign ar_valid = (state == S_AR);
    assign w_valid  = (state == S_W);   // FIFO already holds every beat
    assign b_ready  = (state == S_B);
    assign r_ready  = (state == S_R);

    assign w = udp_axi_pkg::axi_w_t'{
        data: wfifo_beat.data,
        strb: wfifo_beat.strb,
        last: wfifo_beat.last
    };
    assign wfifo_pop = w_valid && w_ready;

    assign rfifo_push = r_valid && r_ready;
    assign rfifo_beat = udp_axi_pkg::rbeat_t'{data: r.data, err: r_bad};

    always_ff @(posedge gmii_rx_clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            err_acc  <= 1'b0;
            axi_done <= 1'b0;
            axi_err  <= 1'b0;
        end else begin
            axi_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd_valid && cmd.status == udp_axi_pkg::STATUS_OK) begin
                        err_acc <= 1'b0;
                        state   <= (cmd.opcode == udp_axi_pkg::OP_WRITE) ? S_AW : S_AR;
                    end
                end
                S_AW: begin
                    if (aw_ready) begin
                        state <= S_W;
                    end
                end
                S_W: begin
                    if (w_ready && wfifo_beat.last) begin
                        state <= S_B;
                    end
                end
                S_B: begin
                    if (b_valid) begin
                        axi_done <= 1'b1;
                        axi_err  <= err_acc | b_bad;
                        state    <= S_IDLE;
                    end
                end
                S_AR: begin
                    if (ar_ready) begin
                        state <= S_R;
                    end
                end
                S_R: begin
                    if (r_valid) begin
                        err_acc <= err_acc | r_bad;
                        if (r.last) begin
                            axi_done <= 1'b1;
                            axi_err  <= err_acc | r_bad;
                            state    <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (state == S_IDLE && cmd_valid) begin
            aw <= udp_axi_pkg::axi_aw_t'{
                id: AXI_ID, addr: cmd.addr, len: cmd.len, burst: udp_axi_pkg::BURST_INCR
            };
            ar <= udp_axi_pkg::axi_ar_t'{
                id: AXI_ID, addr: cmd.addr, len: cmd.len, burst: udp_axi_pkg::BURST_INCR
            };
        end
    end

    assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("AW dropped or changed under back-pressure");

    // W payload comes from the FIFO head
    assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("W dropped or changed under back-pressure");

endmodule

// File: udp_reply_gen.sv
`timescale 1ns/1ps
module udp_reply_gen (
    input  logic                gmii_rx_clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    input  udp_axi_pkg::cmd_t   cmd,
    input  logic                axi_done,
    input  logic                axi_err,
    output logic                rfifo_pop,
    input  udp_axi_pkg::rbeat_t rfifo_beat,
    input  logic                rfifo_empty,
    output logic                tx_start_en,
    output logic [15:0]         tx_byte_num,
    output logic [31:0]         tx_data,
    input  logic                tx_req,
    input  logic                tx_done,
    output logic                reply_done
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_SEND
    } state_t;

    state_t              state;
    udp_axi_pkg::cmd_t   hold;
    udp_axi_pkg::reply_t hdr;
    logic [7:0]          status;
    logic                hdr_sent;
    logic                with_data;  // good read, beats follow
    logic                good_read;

    assign good_read = !axi_err && (hold.opcode == udp_axi_pkg::OP_READ);

    assign hdr = udp_axi_pkg::reply_t'{
        opcode: hold.opcode,
        tag:    hold.tag,
        status: status,
        len:    hold.len
    };
    assign tx_data = hdr_sent ? rfifo_beat.data : hdr;

    // header-only replies drain any beats left from a failed read
    assign rfifo_pop = !rfifo_empty && (state == S_SEND) &&
                       (with_data ? (tx_req && hdr_sent) : 1'b1);

    always_ff @(posedge gmii_rx_clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            tx_start_en <= 1'b0;
            reply_done  <= 1'b0;
            hdr_sent    <= 1'b0;
        end else begin
            tx_start_en <= 1'b0;
            reply_done  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd_valid) begin
                        hdr_sent <= 1'b0;
                        if (cmd.status != udp_axi_pkg::STATUS_OK) begin
                            tx_start_en <= 1'b1;
                            state       <= S_SEND;
                        end else begin
                            state <= S_WAIT;
                        end
                    end
                end
                S_WAIT: begin
                    if (axi_done) begin
                        tx_start_en <= 1'b1;
                        state       <= S_SEND;
                    end
                end
                S_SEND: begin
                    if (tx_req) begin
                        hdr_sent <= 1'b1;
                    end
                    if (tx_done) begin
                        reply_done <= 1'b1;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (state == S_IDLE && cmd_valid) begin
            hold        <= cmd;
            status      <= cmd.status;
            with_data   <= 1'b0;
            tx_byte_num <= 16'd4;
        end
        if (state == S_WAIT && axi_done) begin
            status      <= axi_err ? udp_axi_pkg::STATUS_AXI_ERR : udp_axi_pkg::STATUS_OK;
            with_data   <= good_read;
            tx_byte_num <= good_read ? ({8'd0, hold.len} + 16'd2) << 2 : 16'd4;
        end
    end

    // master flags a bad beat in axi_err too, so an ok reply never carries one
    assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
        rfifo_pop && with_data |-> !rfifo_beat.err)
        else $error("errored read beat sent in an ok reply");

endmodule

// File: udp_axi_cmd.sv
`timescale 1ns/1ps
module udp_axi_cmd #(
    parameter int         MAX_BEATS = 16,
    parameter logic [1:0] AXI_ID    = 2'd0
) (
    input  logic                 gmii_rx_clk,
    input  logic                 rst_n,
    input  logic                 rec_en,
    input  logic [31:0]          rec_data,
    input  logic                 rec_pkt_done,
    output logic                 tx_start_en,
    output logic [15:0]          tx_byte_num,
    output logic [31:0]          tx_data,
    input  logic                 tx_req,
    input  logic                 tx_done,
    output udp_axi_pkg::axi_aw_t aw,
    output logic                 aw_valid,
    input  logic                 aw_ready,
    output udp_axi_pkg::axi_w_t  w,
    output logic                 w_valid,
    input  logic                 w_ready,
    input  udp_axi_pkg::axi_b_t  b,
    input  logic                 b_valid,
    output logic                 b_ready,
    output udp_axi_pkg::axi_ar_t ar,
    output logic                 ar_valid,
    input  logic                 ar_ready,
    input  udp_axi_pkg::axi_r_t  r,
    input  logic                 r_valid,
    output logic                 r_ready
);
    logic                cmd_valid;
    udp_axi_pkg::cmd_t   cmd;
    logic                wfifo_push;
    logic                wfifo_pop;
    logic                wfifo_clear;
    udp_axi_pkg::wbeat_t wfifo_in;
    udp_axi_pkg::wbeat_t wfifo_head;
    logic                rfifo_push;
    logic                rfifo_pop;
    logic                rfifo_empty;
    udp_axi_pkg::rbeat_t rfifo_in;
    udp_axi_pkg::rbeat_t rfifo_head;
    logic                axi_done;
    logic                axi_err;
    logic                reply_done;

    udp_cmd_parser #(
        .MAX_BEATS (MAX_BEATS)
    ) u_parser (
        .gmii_rx_clk  (gmii_rx_clk),
        .rst_n        (rst_n),
        .rec_en       (rec_en),
        .rec_data     (rec_data),
        .rec_pkt_done (rec_pkt_done),
        .reply_done   (reply_done),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .wfifo_push   (wfifo_push),
        .wfifo_beat   (wfifo_in),
        .wfifo_clear  (wfifo_clear)
    );

    word_fifo #(
        .payload_t (udp_axi_pkg::wbeat_t),
        .DEPTH     (MAX_BEATS)
    ) u_wfifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rst_n       (rst_n),
        .clear       (wfifo_clear),
        .push        (wfifo_push),
        .push_data   (wfifo_in),
        .pop         (wfifo_pop),
        .pop_data    (wfifo_head),
        .empty       (),
        .full        ()
    );

    axi_burst_master #(
        .AXI_ID (AXI_ID)
    ) u_master (
        .gmii_rx_clk (gmii_rx_clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .wfifo_pop   (wfifo_pop),
        .wfifo_beat  (wfifo_head),
        .rfifo_push  (rfifo_push),
        .rfifo_beat  (rfifo_in),
        .axi_done    (axi_done),
        .axi_err     (axi_err),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b           (b),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .ar          (ar),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .r           (r),
        .r_valid     (r_valid),
        .r_ready     (r_ready)
    );

    word_fifo #(
        .payload_t (udp_axi_pkg::rbeat_t),
        .DEPTH     (MAX_BEATS)
    ) u_rfifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rst_n       (rst_n),
        .clear       (1'b0),       // reply builder drains it
        .push        (rfifo_push),
        .push_data   (rfifo_in),
        .pop         (rfifo_pop),
        .pop_data    (rfifo_head),
        .empty       (rfifo_empty),
        .full        ()
    );

    udp_reply_gen u_reply (
        .gmii_rx_clk (gmii_rx_clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .axi_done    (axi_done),
        .axi_err     (axi_err),
        .rfifo_pop   (rfifo_pop),
        .rfifo_beat  (rfifo_head),
        .rfifo_empty (rfifo_empty),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .tx_data     (tx_data),
        .tx_req      (tx_req),
        .tx_done     (tx_done),
        .reply_done  (reply_done)
    );

endmodule

// File: axi_mem_model.sv
`timescale 1ns/1ps
module axi_mem_model #(
    parameter int SEED = 75
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  udp_axi_pkg::axi_aw_t aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  udp_axi_pkg::axi_w_t  w,
    input  logic                 w_valid,
    output logic                 w_ready,
    output udp_axi_pkg::axi_b_t  b,
    output logic                 b_valid,
    input  logic                 b_ready,
    input  udp_axi_pkg::axi_ar_t ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output udp_axi_pkg::axi_r_t  r,
    output logic                 r_valid,
    input  logic                 r_ready
);
    localparam logic [1:0] SLVERR = 2'b10;

    logic [31:0] mem [1024];
    logic [31:0] waddr;
    logic [31:0] raddr;
    logic [1:0]  wid;
    logic [1:0]  rid;
    logic        wr_active;
    logic        rd_active;
    logic        werr;       // error region, bad burst or beat count
    logic        rerr;
    logic [7:0]  wleft;      // write beats left minus one
    logic [7:0]  rcnt;       // read beats left minus one
    logic [7:0]  rnd;        // fresh stall bits every cycle
    integer      seed;

    initial seed = SEED;

    assign aw_ready = !wr_active && !b_valid && (rnd[1:0] != 2'b00);
    assign w_ready  = wr_active && (rnd[3:2] != 2'b00);
    assign ar_ready = !rd_active && (rnd[5:4] != 2'b00);
    assign r_valid  = rd_active && (rnd[7:6] != 2'b00);  // master holds rready in the burst
    assign r = udp_axi_pkg::axi_r_t'{
        id:   rid,
        data: mem[raddr[11:2]],
        resp: rerr ? SLVERR : udp_axi_pkg::RESP_OKAY,
        last: (rcnt == 8'd0)
    };

    always @(posedge clk) begin
        rnd <= 8'($random(seed));
        if (!rst_n) begin
            wr_active <= 1'b0;
            rd_active <= 1'b0;
            b_valid   <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                wr_active <= 1'b1;
                waddr     <= aw.addr;
                wid       <= aw.id;
                wleft     <= aw.len;
                werr      <= aw.addr[31] || (aw.burst != udp_axi_pkg::BURST_INCR);
            end
            if (w_valid && w_ready) begin
                for (int i = 0; i < 4; i++) begin
                    if (!werr && w.strb[i]) begin
                        mem[waddr[11:2]][8*i +: 8] <= w.data[8*i +: 8];
                    end
                end
                waddr <= waddr + 32'd4;
                wleft <= wleft - 8'd1;
                if (w.last != (wleft == 8'd0)) begin
                    werr <= 1'b1;  // wlast off the awlen beat
                end
                if (w.last) begin
                    wr_active <= 1'b0;
                    b_valid   <= 1'b1;
                    b         <= udp_axi_pkg::axi_b_t'{
                        id:   wid,
                        resp: (werr || wleft != 8'd0) ? SLVERR : udp_axi_pkg::RESP_OKAY
                    };
                end
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                rd_active <= 1'b1;
                raddr     <= ar.addr;
                rid       <= ar.id;
                rcnt      <= ar.len;
                rerr      <= ar.addr[31] || (ar.burst != udp_axi_pkg::BURST_INCR);
            end
            if (r_valid && r_ready) begin
                raddr <= raddr + 32'd4;
                rcnt  <= rcnt - 8'd1;
                if (rcnt == 8'd0) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

endmodule

// File: tb_udp_axi_cmd.sv
`timescale 1ns/1ps
module tb_udp_axi_cmd;
    localparam int MAX_BEATS  = 16;
    localparam int WAIT_LIMIT = 4000;

    logic                 gmii_rx_clk = 1'b0;
    logic                 rst_n;
    logic                 rec_en;
    logic [31:0]          rec_data;
    logic                 rec_pkt_done;
    logic                 tx_start_en;
    logic [15:0]          tx_byte_num;
    logic [31:0]          tx_data;
    logic                 tx_req;
    logic                 tx_done;
    udp_axi_pkg::axi_aw_t aw;
    logic                 aw_valid;
    logic                 aw_ready;
    udp_axi_pkg::axi_w_t  w;
    logic                 w_valid;
    logic                 w_ready;
    udp_axi_pkg::axi_b_t  b;
    logic                 b_valid;
    logic                 b_ready;
    udp_axi_pkg::axi_ar_t ar;
    logic                 ar_valid;
    logic                 ar_ready;
    udp_axi_pkg::axi_r_t  r;
    logic                 r_valid;
    logic                 r_ready;

    logic [31:0] shadow [1024];  // expected memory contents by word
    logic [31:0] data_q [$];     // write payload of the current test
    logic [31:0] reply_q [$];
    int          valid_cycles = 0;
    integer      seed;
    int          n_pass;
    int          n_fail;

    always #4 gmii_rx_clk = ~gmii_rx_clk;

    always @(posedge gmii_rx_clk) begin
        if (aw_valid || ar_valid) begin
            valid_cycles <= valid_cycles + 1;
        end
    end

    udp_axi_cmd #(
        .MAX_BEATS (MAX_BEATS),
        .AXI_ID    (2'd0)
    ) uut (.*);

    axi_mem_model #(
        .SEED (75)
    ) u_mem (
        .clk      (gmii_rx_clk),
        .rst_n    (rst_n),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    task automatic send_packet(input logic [31:0] hdr, input logic [31:0] addr);
        logic [31:0] words [$];
        words.push_back(hdr);
        words.push_back(addr);
        foreach (data_q[i]) begin
            words.push_back(data_q[i]);
        end
        foreach (words[i]) begin
            rec_en   = 1'b1;
            rec_data = words[i];
            @(negedge gmii_rx_clk);
        end
        rec_en       = 1'b0;
        rec_pkt_done = 1'b1;
        @(negedge gmii_rx_clk);
        rec_pkt_done = 1'b0;
    endtask

    // plays the UDP stack's transmit side
    task automatic collect_reply(input string name, output bit seen, output logic [15:0] nbytes);
        int waited;
        waited = 0;
        seen   = 1'b0;
        nbytes = 16'd0;
        reply_q.delete();
        while (!tx_start_en && waited < WAIT_LIMIT) begin
            @(negedge gmii_rx_clk);
            waited++;
        end
        if (!tx_start_en) begin
            $display("%s: no tx_start_en within %0d cycles", name, WAIT_LIMIT);
        end else begin
            seen   = 1'b1;
            nbytes = tx_byte_num;
            for (int i = 0; i < int'(nbytes / 4) && i < 64; i++) begin
                reply_q.push_back(tx_data);
                tx_req = 1'b1;
                @(negedge gmii_rx_clk);
                tx_req = 1'b0;
                @(negedge gmii_rx_clk);
            end
            tx_done = 1'b1;
            @(negedge gmii_rx_clk);
            tx_done = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input logic [31:0] hdr, input logic [31:0] addr,
                            input logic [7:0] exp_status);
        logic [31:0] exp_q [$];
        logic [15:0] exp_bytes;
        logic [15:0] nbytes;
        bit          good_read;
        bit          seen;
        bit          bad;
        int          cycles_before;
        bad       = 1'b0;
        good_read = (exp_status == udp_axi_pkg::STATUS_OK) &&
                    (hdr[31:24] == udp_axi_pkg::OP_READ);
        exp_bytes = good_read ? 16'((int'(hdr[7:0]) + 2) * 4) : 16'd4;
        exp_q.push_back({hdr[31:16], exp_status, hdr[7:0]});
        if (good_read) begin
            for (int i = 0; i <= int'(hdr[7:0]); i++) begin
                exp_q.push_back(shadow[10'(int'(addr[11:2]) + i)]);
            end
        end
        cycles_before = valid_cycles;
        send_packet(hdr, addr);
        collect_reply(name, seen, nbytes);
        if (!seen) begin
            bad = 1'b1;
        end else begin
            if (nbytes !== exp_bytes) begin
                $display("FAILED %s byte count: expected %0d, actual %0d", name, exp_bytes, nbytes);
                bad = 1'b1;
            end
            foreach (exp_q[i]) begin
                if (i >= reply_q.size()) begin
                    $display("%s: reply ended before word %0d", name, i);
                    bad = 1'b1;
                    break;
                end
                if (reply_q[i] !== exp_q[i]) begin
                    $display("FAILED %s word %0d: expected %h, actual %h",
                             name, i, exp_q[i], reply_q[i]);
                    bad = 1'b1;
                end
            end
        end
        if ((exp_status == udp_axi_pkg::STATUS_BAD_OP || exp_status == udp_axi_pkg::STATUS_BAD_LEN)
            && valid_cycles != cycles_before) begin
            $display("%s: AXI address valid seen for a rejected command", name);
            bad = 1'b1;
        end
        if (exp_status == udp_axi_pkg::STATUS_OK && hdr[31:24] == udp_axi_pkg::OP_WRITE) begin
            foreach (data_q[i]) begin
                shadow[10'(int'(addr[11:2]) + i)] = data_q[i];
            end
        end
        if (bad) begin
            n_fail++;
        end else begin
            n_pass++;
        end
        $display("test %s: %s", name, bad ? "failed" : "passed");
        repeat (4) @(negedge gmii_rx_clk);  // lets busy clear before the next packet
    endtask

    initial begin
        string       name;
        string       rest;
        logic [31:0] hdr;
        logic [31:0] addr;
        logic [31:0] word;
        logic [7:0]  status;
        int          rnd;
        int          cnt;
        int          fd;
        int          code;
        seed         = 75;
        n_pass       = 0;
        n_fail       = 0;
        rst_n        = 1'b0;
        rec_en       = 1'b0;
        rec_data     = 32'd0;
        rec_pkt_done = 1'b0;
        tx_req       = 1'b0;
        tx_done      = 1'b0;
        repeat (16) @(negedge gmii_rx_clk);
        rst_n = 1'b1;
        repeat (2) @(negedge gmii_rx_clk);
        fd = $fopen("udp_axi_cmd_input.txt", "r");
        if (fd == 0) begin
            $display("could not open udp_axi_cmd_input.txt");
            n_fail++;
        end else begin
            while ($fscanf(fd, "%s", name) == 1) begin
                if (name.getc(0) == "#") begin
                    code = $fgets(rest, fd);  // rest of a comment line
                end else begin
                    data_q.delete();
                    code = $fscanf(fd, "%h %h %h %d %d", hdr, addr, status, rnd, cnt);
                    if (code != 5) begin
                        $display("line for %s could not be parsed", name);
                        n_fail++;
                        break;
                    end
                    for (int i = 0; i < cnt; i++) begin
                        if (rnd != 0) begin
                            word = $random(seed);
                        end else begin
                            code = $fscanf(fd, "%h", word);
                        end
                        data_q.push_back(word);
                    end
                    run_test(name, hdr, addr, status);
                end
            end
            $fclose(fd);
        end
        $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && n_pass > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: udp_axi_cmd_input.txt
# name header address status random count data...
# status 0 ok 1 axi error 2 bad opcode 3 bad length, random 1 draws count data words from $random
write_burst4 01110003 00000100 0 0 4 11111111 22222222 33333333 44444444
read_back4 02120003 00000100 0 0 0
write_slverr 01130001 80000040 1 0 2 deadbeef cafef00d
bad_opcode 03140000 00000100 2 0 0
short_write 01150003 00000100 3 0 2 55555555 66666666
read_after_flush 02160003 00000100 0 0 0
write_single 011a0000 00000108 0 0 1 77777777
read_mixed 021b0003 00000100 0 0 0
read_slverr 02190001 80000080 1 0 0
over_limit 021c0010 00000100 3 0 0
rand_write16 0117000f 00000200 0 1 16
rand_read16 0218000f 00000200 0 0 0

// File: udp_axi_cmd.f
udp_axi_pkg.sv
word_fifo.sv
udp_cmd_parser.sv
axi_burst_master.sv
udp_reply_gen.sv
udp_axi_cmd.sv
axi_mem_model.sv
tb_udp_axi_cmd.sv

// File: Bender.yml
package:
  name: udp_axi_cmd

sources:
  - udp_axi_pkg.sv
  - word_fifo.sv
  - udp_cmd_parser.sv
  - axi_burst_master.sv
  - udp_reply_gen.sv
  - udp_axi_cmd.sv
  - target: test
    files:
      - axi_mem_model.sv
      - tb_udp_axi_cmd.sv
